// File: if_bus_pkg.sv
////////////////////////////////////////////////////////////
// instruction bus request/response, fetch queue entry
// and IF-ID payload structs
////////////////////////////////////////////////////////////

`include "if_macros.svh"

package if_bus_pkg;

  //////////////////////////////////////////////////////////
  // instruction bus
  //////////////////////////////////////////////////////////

  // request side, held until granted
  typedef struct packed {
    logic                req;
    logic [`IF_XLEN-1:0] addr;
  } instr_req_t;

  // grant plus in-order response
  typedef struct packed {
    logic                gnt;
    logic                rvalid;
    logic [`IF_XLEN-1:0] rdata;
    logic                err;
  } instr_rsp_t;

  //////////////////////////////////////////////////////////
  // internal payloads
  //////////////////////////////////////////////////////////

  // one fetched word tagged with its address
  typedef struct packed {
    logic [`IF_XLEN-1:0] addr;
    logic [`IF_XLEN-1:0] rdata;
    logic                err;
  } fetch_entry_t;

  // contents of the IF-ID pipeline register
  typedef struct packed {
    logic [`IF_XLEN-1:0] instr;
    logic [`IF_XLEN-1:0] pc;
    logic                fetch_err;
  } if_id_t;

endpackage

// File: if_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// control encodings for PC selection, exception vector
// selection and interrupt ids
////////////////////////////////////////////////////////////

package if_ctrl_pkg;

  //////////////////////////////////////////////////////////
  // next fetch address source
  //////////////////////////////////////////////////////////

  // boot vector, jump/branch target, trap vector,
  // return from trap, return from debug
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  //////////////////////////////////////////////////////////
  // exception vector source
  //////////////////////////////////////////////////////////

  // synchronous exception, vectored interrupt,
  // debug halt request, exception while in debug mode
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  // interrupt line number, scaled by 4 into the vector table
  typedef logic [4:0] irq_id_t;

endpackage

// File: if_fetch_ctrl.sv
////////////////////////////////////////////////////////////
// prefetch request control, outstanding tracking and
// stale response discard after redirects
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "if_macros.svh"

module if_fetch_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  logic                       pc_set_i,
  input  logic [`IF_XLEN-1:0]        fetch_addr_i,
  input  if_bus_pkg::instr_rsp_t     instr_rsp_i,
  input  logic [`IF_FIFO_CNT_W-1:0]  fifo_count_i,
  output if_bus_pkg::instr_req_t     instr_req_o,
  output logic                       push_o,
  output if_bus_pkg::fetch_entry_t   push_entry_o,
  output logic                       flush_o,
  output logic                       busy_o
);

  localparam int cnt_w = $clog2(`IF_MAX_OUTSTANDING + 1);
  localparam int ptr_w = (`IF_MAX_OUTSTANDING > 1) ? $clog2(`IF_MAX_OUTSTANDING) : 1;
  localparam int occ_w = cnt_w + `IF_FIFO_CNT_W;

  logic                 started_q;
  logic                 pend_q;
  logic [`IF_XLEN-1:0]  next_addr_q;
  logic [cnt_w-1:0]     out_cnt_q;
  logic [cnt_w-1:0]     discard_q;
  logic [ptr_w-1:0]     wr_ptr_q;
  logic [ptr_w-1:0]     rd_ptr_q;
  logic [`IF_XLEN-1:0]  addr_mem_q [`IF_MAX_OUTSTANDING];

  logic [occ_w-1:0]     occupancy;
  logic                 space;
  logic                 req;
  logic [`IF_XLEN-1:0]  addr;
  logic                 grant;
  logic                 rvalid;
  logic                 stale;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    ptr_inc = (ptr == ptr_w'(`IF_MAX_OUTSTANDING - 1)) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////

  // queue is flushed at a redirect edge, count it as empty
  assign occupancy = occ_w'(pc_set_i ? '0 : fifo_count_i) + occ_w'(out_cnt_q);
  assign space     = (occupancy < occ_w'(`IF_FIFO_DEPTH)) &
                     (out_cnt_q < cnt_w'(`IF_MAX_OUTSTANDING));

  // an ungranted request is held, unless a redirect replaces it
  assign req  = (pend_q & ~pc_set_i) | ((started_q | pc_set_i) & req_i & space);
  assign addr = pc_set_i ? fetch_addr_i : next_addr_q;

  assign instr_req_o.req  = req;
  assign instr_req_o.addr = addr;

  //////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////

  assign grant  = req & instr_rsp_i.gnt;
  assign rvalid = instr_rsp_i.rvalid;
  // responses still owed to requests from before a redirect
  assign stale  = (discard_q != '0);

  assign push_o             = rvalid & ~stale & ~pc_set_i;
  assign push_entry_o.addr  = addr_mem_q[rd_ptr_q];
  assign push_entry_o.rdata = instr_rsp_i.rdata;
  assign push_entry_o.err   = instr_rsp_i.err;

  assign flush_o = pc_set_i;
  assign busy_o  = (out_cnt_q != '0) | req;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      started_q   <= 1'b0;
      pend_q      <= 1'b0;
      next_addr_q <= '0;
      out_cnt_q   <= '0;
      discard_q   <= '0;
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
    end else begin
      started_q <= started_q | pc_set_i;
      pend_q    <= req & ~instr_rsp_i.gnt;
      out_cnt_q <= out_cnt_q + cnt_w'(grant) - cnt_w'(rvalid);
      // sequential address advances on every grant
      if (grant) begin
        next_addr_q <= addr + `IF_XLEN'(4);
      end else if (pc_set_i) begin
        next_addr_q <= fetch_addr_i;
      end
      // all requests granted before the redirect become stale
      if (pc_set_i) begin
        discard_q <= out_cnt_q - cnt_w'(rvalid);
      end else if (rvalid && stale) begin
        discard_q <= discard_q - cnt_w'(1);
      end
      if (grant) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (rvalid) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  // address of each granted request, in bus order
  always_ff @(posedge clk_i) begin
    if (grant) begin
      addr_mem_q[wr_ptr_q] <= addr;
    end
  end

endmodule

// File: if_fetch_fifo.sv
////////////////////////////////////////////////////////////
// fetch queue, circular buffer of fetched words with
// bypass when empty
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "if_macros.svh"

module if_fetch_fifo (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic                       push_i,
  input  if_bus_pkg::fetch_entry_t   push_entry_i,
  input  logic                       pop_i,
  output logic                       out_valid_o,
  output if_bus_pkg::fetch_entry_t   out_entry_o,
  output logic [`IF_FIFO_CNT_W-1:0]  count_o
);

  localparam int depth = `IF_FIFO_DEPTH;
  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

  if_bus_pkg::fetch_entry_t   mem_q [depth];
  logic [ptr_w-1:0]           wr_ptr_q;
  logic [ptr_w-1:0]           rd_ptr_q;
  logic [`IF_FIFO_CNT_W-1:0]  count_q;

  logic                       empty;
  logic                       bypass;
  logic                       wr_en;
  logic                       rd_en;

  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
    ptr_inc = (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty  = (count_q == '0);
  // word arriving into an empty queue is consumed in the same cycle
  assign bypass = empty & push_i & pop_i;
  assign wr_en  = push_i & ~bypass & ~flush_i;
  assign rd_en  = pop_i & ~empty & ~flush_i;

  // head of queue, or the incoming word when nothing is stored
  assign out_valid_o = ~empty | push_i;
  assign out_entry_o = empty ? push_entry_i : mem_q[rd_ptr_q];
  assign count_o     = count_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // redirect drops everything buffered
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (rd_en) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      count_q <= count_q + `IF_FIFO_CNT_W'(wr_en) - `IF_FIFO_CNT_W'(rd_en);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

endmodule

// File: if_id_reg.sv
////////////////////////////////////////////////////////////
// IF-ID pipeline register with valid/new flags and
// sequential PC increment check
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "if_macros.svh"

module if_id_reg (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      fetch_valid_i,
  input  if_bus_pkg::fetch_entry_t  fetch_entry_i,
  input  logic                      id_in_ready_i,
  input  logic                      pc_set_i,
  input  logic                      instr_valid_clear_i,
  output logic                      pop_o,
  output if_bus_pkg::if_id_t        id_o,
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output logic                      pc_mismatch_alert_o
);

  logic                 load;
  logic                 valid_q;
  logic                 new_q;
  logic                 seq_q;
  if_bus_pkg::if_id_t   id_q;
  logic [`IF_XLEN-1:0]  pc_incr;

  //////////////////////////////////////////////////////////
  // handshake and flags
  //////////////////////////////////////////////////////////

  // a head entry in the redirect cycle is squashed, not loaded
  assign load  = fetch_valid_i & id_in_ready_i & ~pc_set_i;
  assign pop_o = load;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
      seq_q   <= 1'b0;
    end else begin
      // valid holds until ID clears it
      valid_q <= load | (valid_q & ~instr_valid_clear_i);
      // single cycle marker of a fresh load
      new_q   <= load;
      // set by a load, cleared by any redirect
      seq_q   <= (seq_q | load) & ~pc_set_i;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  //////////////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (load) begin
      id_q.instr     <= fetch_entry_i.rdata;
      id_q.pc        <= fetch_entry_i.addr;
      id_q.fetch_err <= fetch_entry_i.err;
    end
  end

  assign id_o = id_q;

  // next instruction of a sequential run must sit one word up
  assign pc_incr             = id_q.pc + `IF_XLEN'(4);
  assign pc_mismatch_alert_o = seq_q & fetch_valid_i & (fetch_entry_i.addr != pc_incr);

endmodule

// File: if_macros.svh
////////////////////////////////////////////////////////////
// shared widths, debug vectors and queue sizing for the
// instruction fetch stage
////////////////////////////////////////////////////////////

`ifndef IF_MACROS_SVH
`define IF_MACROS_SVH

// address and instruction word width
`define IF_XLEN 32

// debug module entry points
`define IF_DM_HALT_ADDR 32'h1A11_0800
`define IF_DM_EXC_ADDR  32'h1A11_0808

// low byte of the reset vector, upper bits come from boot_addr_i
`define IF_BOOT_OFFSET 8'h80

// fetch queue and bus request limits
`define IF_FIFO_DEPTH      2
`define IF_MAX_OUTSTANDING 2

// occupancy counter width of the fetch queue
`define IF_FIFO_CNT_W ($clog2(`IF_FIFO_DEPTH + 1))

`endif

// File: if_pc_select.sv
////////////////////////////////////////////////////////////
// exception vector, next fetch address mux and
// mtvec init request
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "if_macros.svh"

module if_pc_select (
  input  if_ctrl_pkg::pc_sel_e     pc_mux_i,
  input  if_ctrl_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_ctrl_pkg::irq_id_t     irq_id_i,
  input  logic [`IF_XLEN-1:0]      boot_addr_i,
  input  logic [`IF_XLEN-1:0]      branch_target_i,
  input  logic [`IF_XLEN-1:0]      csr_mepc_i,
  input  logic [`IF_XLEN-1:0]      csr_depc_i,
  input  logic [`IF_XLEN-1:0]      csr_mtvec_i,
  input  logic                     pc_set_i,
  output logic [`IF_XLEN-1:0]      fetch_addr_o,
  output logic                     csr_mtvec_init_o
);

  logic [`IF_XLEN-1:0] exc_pc;
  logic [`IF_XLEN-1:0] fetch_addr;

  // trap vector, base taken from mtvec with 256 byte alignment
  always_comb begin
    unique case (exc_pc_mux_i)
      if_ctrl_pkg::EXC_PC_EXC:     exc_pc = {csr_mtvec_i[`IF_XLEN-1:8], 8'h00};
      // vectored mode, one word per interrupt line
      if_ctrl_pkg::EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[`IF_XLEN-1:8], 1'b0, irq_id_i, 2'b00};
      if_ctrl_pkg::EXC_PC_DBD:     exc_pc = `IF_DM_HALT_ADDR;
      if_ctrl_pkg::EXC_PC_DBG_EXC: exc_pc = `IF_DM_EXC_ADDR;
      default:                     exc_pc = {csr_mtvec_i[`IF_XLEN-1:8], 8'h00};
    endcase
  end

  // next fetch address
  always_comb begin
    case (pc_mux_i)
      if_ctrl_pkg::PC_BOOT: fetch_addr = {boot_addr_i[`IF_XLEN-1:8], `IF_BOOT_OFFSET};
      if_ctrl_pkg::PC_JUMP: fetch_addr = branch_target_i;
      if_ctrl_pkg::PC_EXC:  fetch_addr = exc_pc;
      // return from trap handler
      if_ctrl_pkg::PC_ERET: fetch_addr = csr_mepc_i;
      // return from debug mode
      if_ctrl_pkg::PC_DRET: fetch_addr = csr_depc_i;
      default:              fetch_addr = {boot_addr_i[`IF_XLEN-1:8], `IF_BOOT_OFFSET};
    endcase
  end

  // 32-bit only, low two bits always clear
  assign fetch_addr_o = {fetch_addr[`IF_XLEN-1:2], 2'b00};

  // csr file loads its mtvec reset value on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_ctrl_pkg::PC_BOOT);

endmodule

// File: if_stage.f
+incdir+.
if_ctrl_pkg.sv
if_bus_pkg.sv
if_pc_select.sv
if_fetch_ctrl.sv
if_fetch_fifo.sv
if_id_reg.sv
if_stage.sv
tb_if_stage.sv

// File: if_stage.sv
////////////////////////////////////////////////////////////
// instruction fetch stage top level
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "if_macros.svh"

module if_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic [`IF_XLEN-1:0]       boot_addr_i,
  input  logic                      pc_set_i,
  input  if_ctrl_pkg::pc_sel_e      pc_mux_i,
  input  if_ctrl_pkg::exc_pc_sel_e  exc_pc_mux_i,
  input  if_ctrl_pkg::irq_id_t      irq_id_i,
  input  logic [`IF_XLEN-1:0]       branch_target_i,
  input  logic [`IF_XLEN-1:0]       csr_mepc_i,
  input  logic [`IF_XLEN-1:0]       csr_depc_i,
  input  logic [`IF_XLEN-1:0]       csr_mtvec_i,
  input  if_bus_pkg::instr_rsp_t    instr_rsp_i,
  input  logic                      id_in_ready_i,
  input  logic                      instr_valid_clear_i,
  output if_bus_pkg::instr_req_t    instr_req_o,
  output if_bus_pkg::if_id_t        id_o,
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output logic [`IF_XLEN-1:0]       pc_if_o,
  output logic                      csr_mtvec_init_o,
  output logic                      pc_mismatch_alert_o,
  output logic                      if_busy_o
);

  logic [`IF_XLEN-1:0]        fetch_addr;
  logic                       push;
  if_bus_pkg::fetch_entry_t   push_entry;
  logic                       flush;
  logic                       fifo_valid;
  if_bus_pkg::fetch_entry_t   fifo_entry;
  logic [`IF_FIFO_CNT_W-1:0]  fifo_count;
  logic                       pop;

  // address of the instruction waiting at the queue head
  assign pc_if_o = fifo_entry.addr;

  if_pc_select u_pc_select (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_id_i         (irq_id_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .pc_set_i         (pc_set_i),
    .fetch_addr_o     (fetch_addr),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  if_fetch_ctrl u_fetch_ctrl (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (req_i), .pc_set_i (pc_set_i),
    .fetch_addr_i (fetch_addr), .instr_rsp_i (instr_rsp_i), .fifo_count_i (fifo_count),
    .instr_req_o (instr_req_o), .push_o (push), .push_entry_o (push_entry),
    .flush_o (flush), .busy_o (if_busy_o)
  );

  if_fetch_fifo u_fetch_fifo (
    .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush), .push_i (push),
    .push_entry_i (push_entry), .pop_i (pop), .out_valid_o (fifo_valid),
    .out_entry_o (fifo_entry), .count_o (fifo_count)
  );

  if_id_reg u_id_reg (
    .clk_i (clk_i), .rst_ni (rst_ni), .fetch_valid_i (fifo_valid), .fetch_entry_i (fifo_entry),
    .id_in_ready_i (id_in_ready_i), .pc_set_i (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i), .pop_o (pop), .id_o (id_o),
    .instr_valid_id_o (instr_valid_id_o), .instr_new_id_o (instr_new_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

// File: tb_if_stage.sv
////////////////////////////////////////////////////////////
// testbench for the fetch stage, bus memory model,
// random stimulus and reference model of the IF-ID stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "if_macros.svh"

module tb_if_stage;

  localparam logic [31:0] data_key   = 32'h5a5a_c3c3;
  localparam logic [31:0] err_base   = 32'h0004_1000;
  localparam logic [31:0] err_size   = 32'h0000_0040;
  // cycle budgets of boot, stream, redirect, vector and error tests
  localparam int          max_cycles = 40 + 400 + 12 * 40 + 4 * 40 + 300 + 200;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          req_i;
  logic                          pc_set_i;
  if_ctrl_pkg::pc_sel_e          pc_mux_i;
  if_ctrl_pkg::exc_pc_sel_e      exc_pc_mux_i;
  if_ctrl_pkg::irq_id_t          irq_id_i;
  logic [31:0]                   boot_addr_i;
  logic [31:0]                   branch_target_i;
  logic [31:0]                   csr_mepc_i;
  logic [31:0]                   csr_depc_i;
  logic [31:0]                   csr_mtvec_i;
  if_bus_pkg::instr_rsp_t        instr_rsp_i;
  logic                          id_in_ready_i;
  logic                          instr_valid_clear_i;
  if_bus_pkg::instr_req_t        instr_req_o;
  if_bus_pkg::if_id_t            id_o;
  logic                          instr_valid_id_o;
  logic                          instr_new_id_o;
  logic [31:0]                   pc_if_o;
  logic                          csr_mtvec_init_o;
  logic                          pc_mismatch_alert_o;
  logic                          if_busy_o;

  // memory model queues of granted requests in bus order
  logic [31:0] mem_addr_q [$];
  int          mem_due_q [$];
  bit          mem_cur_q [$];

  // reference model state
  int          cycle = 0;
  int          errors = 0;
  int          loads = 0;
  int          buffered = 0;
  bit          started = 1'b0;
  bit          pend = 1'b0;
  bit          stress = 1'b0;
  bit          clear_en = 1'b0;
  bit          exp_new = 1'b0;
  bit          exp_valid = 1'b0;
  logic [31:0] exp_pc = '0;
  logic [31:0] exp_id_pc = '0;
  logic [31:0] next_req_addr = '0;

  if_stage dut_i (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (req_i), .boot_addr_i (boot_addr_i),
    .pc_set_i (pc_set_i), .pc_mux_i (pc_mux_i), .exc_pc_mux_i (exc_pc_mux_i),
    .irq_id_i (irq_id_i), .branch_target_i (branch_target_i), .csr_mepc_i (csr_mepc_i),
    .csr_depc_i (csr_depc_i), .csr_mtvec_i (csr_mtvec_i), .instr_rsp_i (instr_rsp_i),
    .id_in_ready_i (id_in_ready_i), .instr_valid_clear_i (instr_valid_clear_i),
    .instr_req_o (instr_req_o), .id_o (id_o), .instr_valid_id_o (instr_valid_id_o),
    .instr_new_id_o (instr_new_id_o), .pc_if_o (pc_if_o),
    .csr_mtvec_init_o (csr_mtvec_init_o), .pc_mismatch_alert_o (pc_mismatch_alert_o),
    .if_busy_o (if_busy_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // watchdog on the cycle counter
  initial begin
    wait (cycle > max_cycles);
    $display("timeout, run did not finish within %0d cycles", max_cycles);
    $display("*** FAILED ***");
    $finish;
  end

  function automatic logic in_err_region(input logic [31:0] addr);
    return (addr >= err_base) && (addr < err_base + err_size);
  endfunction

  // trap vector from mtvec base, interrupt table or debug entry points
  function automatic logic [31:0] vector_addr(input if_ctrl_pkg::exc_pc_sel_e sel,
                                              input logic [31:0] mtvec, input logic [4:0] irq);
    case (sel)
      if_ctrl_pkg::EXC_PC_EXC: return mtvec & 32'hffff_ff00;
      if_ctrl_pkg::EXC_PC_IRQ: return (mtvec & 32'hffff_ff00) + 32'(irq) * 4;
      if_ctrl_pkg::EXC_PC_DBD: return `IF_DM_HALT_ADDR;
      default:                 return `IF_DM_EXC_ADDR;
    endcase
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    errors++;
    $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
  endtask

  ////////////////////////////////////////////////////////////
  // one clock cycle of stimulus, bus model and checks
  ////////////////////////////////////////////////////////////

  task automatic run_cycle(input bit set, input if_ctrl_pkg::pc_sel_e mux,
                           input if_ctrl_pkg::exc_pc_sel_e exc_sel, input logic [31:0] jump_to);
    logic [31:0] target;
    int          occ;
    bit          rsp;
    bit          push_now;
    bit          load_now;
    bit          exp_req;
    @(negedge clk_i);
    cycle++;
    // registered outputs from the last rising edge
    if (instr_new_id_o !== exp_new) report_mismatch("instr_new_id_o", exp_new, instr_new_id_o);
    if (instr_valid_id_o !== exp_valid)
      report_mismatch("instr_valid_id_o", exp_valid, instr_valid_id_o);
    if (exp_new) begin
      if (id_o.pc !== exp_id_pc) report_mismatch("id_o.pc", exp_id_pc, id_o.pc);
      if (id_o.instr !== (exp_id_pc ^ data_key))
        report_mismatch("id_o.instr", exp_id_pc ^ data_key, id_o.instr);
      if (id_o.fetch_err !== in_err_region(exp_id_pc))
        report_mismatch("id_o.fetch_err", in_err_region(exp_id_pc), id_o.fetch_err);
    end
    // csr values only change with a redirect
    pc_set_i     = set;
    pc_mux_i     = mux;
    exc_pc_mux_i = exc_sel;
    if (set) begin
      boot_addr_i     = $urandom;
      branch_target_i = jump_to;
      csr_mepc_i      = $urandom;
      csr_depc_i      = $urandom;
      csr_mtvec_i     = $urandom;
      irq_id_i        = if_ctrl_pkg::irq_id_t'($urandom);
    end
    id_in_ready_i       = stress ? ($urandom % 3 != 0) : 1'b1;
    instr_valid_clear_i = clear_en ? ($urandom % 4 == 0) : 1'b0;
    instr_rsp_i         = '0;
    instr_rsp_i.gnt     = ($urandom % 4 != 0);
    rsp = 1'b0;
    if (mem_addr_q.size() > 0) begin
      rsp = (cycle >= mem_due_q[0]);
    end
    if (rsp) begin
      instr_rsp_i.rvalid = 1'b1;
      instr_rsp_i.rdata  = mem_addr_q[0] ^ data_key;
      instr_rsp_i.err    = in_err_region(mem_addr_q[0]);
    end
    #1;
    if (set) begin
      case (mux)
        if_ctrl_pkg::PC_BOOT: target = (boot_addr_i & 32'hffff_ff00) | 32'h80;
        if_ctrl_pkg::PC_JUMP: target = branch_target_i;
        if_ctrl_pkg::PC_EXC:  target = vector_addr(exc_sel, csr_mtvec_i, irq_id_i);
        if_ctrl_pkg::PC_ERET: target = csr_mepc_i;
        default:              target = csr_depc_i;
      endcase
      target        = target & 32'hffff_fffc;
      exp_pc        = target;
      next_req_addr = target;
      buffered      = 0;
      started       = 1'b1;
      // everything in flight belongs to the old stream now
      foreach (mem_cur_q[i]) mem_cur_q[i] = 1'b0;
    end
    if (csr_mtvec_init_o !== (set && mux == if_ctrl_pkg::PC_BOOT))
      report_mismatch("csr_mtvec_init_o", set && mux == if_ctrl_pkg::PC_BOOT, csr_mtvec_init_o);
    occ     = mem_addr_q.size() + buffered;
    exp_req = (pend && !set) || (started && req_i && occ < `IF_FIFO_DEPTH &&
                                 mem_addr_q.size() < `IF_MAX_OUTSTANDING);
    if (instr_req_o.req && !(pend && !set) && occ >= `IF_FIFO_DEPTH) begin
      errors++;
      $display("request at %0t ns with no room left in the fetch queue", $time);
    end
    if (instr_req_o.req !== exp_req) report_mismatch("instr_req_o.req", exp_req, instr_req_o.req);
    if (exp_req && instr_req_o.addr !== next_req_addr)
      report_mismatch("instr_req_o.addr", next_req_addr, instr_req_o.addr);
    if (if_busy_o !== (exp_req || mem_addr_q.size() != 0))
      report_mismatch("if_busy_o", exp_req || mem_addr_q.size() != 0, if_busy_o);
    if (pc_mismatch_alert_o !== 1'b0)
      report_mismatch("pc_mismatch_alert_o", 0, pc_mismatch_alert_o);
    push_now = rsp && mem_cur_q[0] && !set;
    load_now = (buffered > 0 || push_now) && id_in_ready_i && !set;
    if ((buffered > 0 || push_now) && !set && pc_if_o !== exp_pc)
      report_mismatch("pc_if_o", exp_pc, pc_if_o);
    // bus handshake at the coming rising edge
    if (rsp) begin
      void'(mem_addr_q.pop_front());
      void'(mem_due_q.pop_front());
      void'(mem_cur_q.pop_front());
    end
    if (exp_req && instr_rsp_i.gnt) begin
      mem_addr_q.push_back(next_req_addr);
      mem_due_q.push_back(cycle + 1 + int'($urandom % 4));
      mem_cur_q.push_back(1'b1);
      next_req_addr = next_req_addr + 32'd4;
    end
    pend      = exp_req && !instr_rsp_i.gnt;
    buffered  = buffered + int'(push_now) - int'(load_now);
    exp_new   = load_now;
    exp_valid = load_now || (exp_valid && !instr_valid_clear_i);
    if (load_now) begin
      exp_id_pc = exp_pc;
      exp_pc    = exp_pc + 32'd4;
      loads++;
    end
  endtask

  task automatic wait_loads(input int n);
    int goal;
    goal = loads + n;
    while (loads < goal) begin
      run_cycle(1'b0, if_ctrl_pkg::PC_BOOT, if_ctrl_pkg::EXC_PC_EXC, 32'h0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    if_ctrl_pkg::pc_sel_e mux;
    void'($urandom(32'had01a626));
    rst_ni              = 1'b0;
    req_i               = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = if_ctrl_pkg::PC_BOOT;
    exc_pc_mux_i        = if_ctrl_pkg::EXC_PC_EXC;
    irq_id_i            = '0;
    boot_addr_i         = '0;
    branch_target_i     = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    csr_mtvec_i         = '0;
    instr_rsp_i         = '0;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    if (instr_req_o.req !== 1'b0) report_mismatch("instr_req_o.req", 0, instr_req_o.req);
    if (instr_valid_id_o !== 1'b0) report_mismatch("instr_valid_id_o", 0, instr_valid_id_o);
    if (instr_new_id_o !== 1'b0) report_mismatch("instr_new_id_o", 0, instr_new_id_o);
    if (pc_mismatch_alert_o !== 1'b0)
      report_mismatch("pc_mismatch_alert_o", 0, pc_mismatch_alert_o);
    if (if_busy_o !== 1'b0) report_mismatch("if_busy_o", 0, if_busy_o);
    rst_ni = 1'b1;
    req_i  = 1'b1;
    // no request may appear before the boot jump
    repeat (2) run_cycle(1'b0, if_ctrl_pkg::PC_BOOT, if_ctrl_pkg::EXC_PC_EXC, 32'h0);
    run_cycle(1'b1, if_ctrl_pkg::PC_BOOT, if_ctrl_pkg::EXC_PC_EXC, 32'h0);
    wait_loads(1);
    // sequential stream with back-pressure
    stress = 1'b1;
    wait_loads(40);
    // redirects mid-stream with random valid clears
    clear_en = 1'b1;
    repeat (12) begin
      repeat ($urandom % 6) run_cycle(1'b0, if_ctrl_pkg::PC_BOOT, if_ctrl_pkg::EXC_PC_EXC, 0);
      case ($urandom % 3)
        0:       mux = if_ctrl_pkg::PC_JUMP;
        1:       mux = if_ctrl_pkg::PC_ERET;
        default: mux = if_ctrl_pkg::PC_DRET;
      endcase
      run_cycle(1'b1, mux, if_ctrl_pkg::EXC_PC_EXC, $urandom);
    end
    wait_loads(3);
    // every trap vector source
    for (int i = 0; i < 4; i++) begin
      run_cycle(1'b1, if_ctrl_pkg::PC_EXC, if_ctrl_pkg::exc_pc_sel_e'(i), 32'h0);
      wait_loads(2);
    end
    // run through the error region
    run_cycle(1'b1, if_ctrl_pkg::PC_JUMP, if_ctrl_pkg::EXC_PC_EXC, err_base - 32'h20);
    wait_loads(24);
    $display("run complete after %0d cycles, %0d loads, %0d errors", cycle, loads, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
